//--- hdl/wb_cfg_pkg.sv
package wb_cfg_pkg;

    // Byte address width
    localparam int ADDR_W = 32;

    // One cache line
    localparam int LINE_W = 128;

    // Byte offset bits inside a line
    localparam int OFFS_W = 4;

    // Queue entries as a power of two
    localparam int WB_DEPTH = 4;

    localparam int IDX_W = $clog2(WB_DEPTH);

    // Byte address
    typedef logic [ADDR_W-1:0] addr_t;

    // Cache line payload
    typedef logic [LINE_W-1:0] line_t;

    // Queue slot number
    typedef logic [IDX_W-1:0] idx_t;

endpackage

//--- hdl/wb_bus_pkg.sv
package wb_bus_pkg;

    import wb_cfg_pkg::*;

    // CPU write request
    typedef struct packed {
        addr_t addr;
        line_t data;
    } cpu_wreq_t;

    // CPU read response
    typedef struct packed {
        logic  hit;
        line_t data;
    } cpu_rresp_t;

    // Line-aligned beat to memory
    typedef struct packed {
        addr_t addr;
        line_t data;
    } mem_wbeat_t;

endpackage

//--- hdl/lutram_1w_mr.sv
`timescale 1ns/1ps

module lutram_1w_mr #(
    parameter int WIDTH          = 32,
    parameter int DEPTH          = 4,
    parameter int NUM_READ_PORTS = 2
) (
    input  logic                                           clk,
    input  logic [$clog2(DEPTH)-1:0]                       waddr_i,
    input  logic                                           wen_i,
    input  logic [WIDTH-1:0]                               wdata_i,
    input  logic [NUM_READ_PORTS-1:0][$clog2(DEPTH)-1:0]   raddr_i,
    output logic [NUM_READ_PORTS-1:0][WIDTH-1:0]           rdata_o
);

    logic [WIDTH-1:0] ram [DEPTH];

    always_ff @(posedge clk) begin
        if (wen_i) begin
            ram[waddr_i] <= wdata_i;
        end
    end

    // Asynchronous reads on every port
    always_comb begin
        for (int p = 0; p < NUM_READ_PORTS; p++) begin
            rdata_o[p] = ram[raddr_i[p]];
        end
    end

endmodule

//--- hdl/dcache_fifo.sv
`timescale 1ns/1ps

module dcache_fifo (
    input  logic                   clk,
    input  logic                   rst,

    // CPU write
    input  logic                   cpu_wvalid_i,
    output logic                   cpu_wready_o,
    input  wb_bus_pkg::cpu_wreq_t  cpu_wreq_i,

    // CPU read
    input  logic                   cpu_rreq_i,
    input  wb_cfg_pkg::addr_t      cpu_raddr_i,
    output wb_bus_pkg::cpu_rresp_t cpu_rresp_o,

    // Head towards the drain stage
    input  logic                   pop_i,
    output logic                   head_valid_o,
    output wb_bus_pkg::mem_wbeat_t head_beat_o
);

    import wb_cfg_pkg::*;

    idx_t                  head;
    idx_t                  tail;
    logic [WB_DEPTH-1:0]   slot_vld;
    addr_t                 tag_q [WB_DEPTH];

    addr_t                 waddr_line;
    addr_t                 raddr_line;
    logic [WB_DEPTH-1:0]   wmatch;
    logic [WB_DEPTH-1:0]   rhit_q;
    logic                  merge;
    logic                  full;
    logic                  w_fire;
    logic                  alloc;
    logic                  pop_fire;
    idx_t                  merge_idx;
    idx_t                  rd_idx;
    idx_t                  ram_waddr;

    logic [1:0][IDX_W-1:0]  ram_raddr;
    logic [1:0][LINE_W-1:0] ram_rdata;

    function automatic addr_t line_align(input addr_t addr);
        return {addr[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
    endfunction

    function automatic idx_t onehot_idx(input logic [WB_DEPTH-1:0] vec);
        idx_t idx;
        idx = '0;
        for (int i = 0; i < WB_DEPTH; i++) begin
            if (vec[i]) begin
                idx = idx_t'(i);
            end
        end
        return idx;
    endfunction

    assign waddr_line = line_align(cpu_wreq_i.addr);
    assign raddr_line = line_align(cpu_raddr_i);

    // Tail slot still occupied means every slot is taken
    assign full         = slot_vld[tail];
    assign head_valid_o = slot_vld[head];
    assign pop_fire     = pop_i & head_valid_o;

    // Head leaving this cycle cannot take a merge
    always_comb begin
        for (int i = 0; i < WB_DEPTH; i++) begin
            wmatch[i] = slot_vld[i] && (tag_q[i] == waddr_line)
                        && !(pop_fire && (head == idx_t'(i)));
        end
    end

    assign merge        = |wmatch;
    assign merge_idx    = onehot_idx(wmatch);
    assign cpu_wready_o = !full || merge;
    assign w_fire       = cpu_wvalid_i & cpu_wready_o;
    assign alloc        = w_fire & !merge;
    assign ram_waddr    = merge ? merge_idx : tail;

    always_ff @(posedge clk) begin
        if (rst) begin
            head     <= '0;
            tail     <= '0;
            slot_vld <= '0;
        end else begin
            // Alloc and pop never hit the same slot
            if (alloc) begin
                slot_vld[tail] <= 1'b1;
                tail           <= tail + 1'b1;
            end
            if (pop_fire) begin
                slot_vld[head] <= 1'b0;
                head           <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            tag_q[tail] <= waddr_line;
        end
    end

    // Read lookup on the request edge
    always_ff @(posedge clk) begin
        if (rst) begin
            rhit_q <= '0;
        end else begin
            for (int i = 0; i < WB_DEPTH; i++) begin
                rhit_q[i] <= cpu_rreq_i && slot_vld[i] && (tag_q[i] == raddr_line);
            end
        end
    end

    assign rd_idx = onehot_idx(rhit_q);

    // Port 1 serves reads, port 0 the head
    assign ram_raddr = {rd_idx, head};

    lutram_1w_mr #(
        .WIDTH          (LINE_W),
        .DEPTH          (WB_DEPTH),
        .NUM_READ_PORTS (2)
    ) u_line_ram (
        .clk     (clk),
        .waddr_i (ram_waddr),
        .wen_i   (w_fire),
        .wdata_i (cpu_wreq_i.data),
        .raddr_i (ram_raddr),
        .rdata_o (ram_rdata)
    );

    assign cpu_rresp_o.hit  = |rhit_q;
    assign cpu_rresp_o.data = (|rhit_q) ? ram_rdata[1] : '0;

    assign head_beat_o.addr = tag_q[head];
    assign head_beat_o.data = ram_rdata[0];

endmodule

//--- hdl/wb_drain.sv
`timescale 1ns/1ps

module wb_drain (
    input  logic                   clk,
    input  logic                   rst,

    // From the queue head
    input  logic                   head_valid_i,
    input  wb_bus_pkg::mem_wbeat_t head_beat_i,
    output logic                   pop_o,

    // Memory write channel
    output logic                   mem_wvalid_o,
    input  logic                   mem_wready_i,
    output wb_bus_pkg::mem_wbeat_t mem_wbeat_o
);

    import wb_bus_pkg::*;

    typedef enum logic {
        IDLE,
        BUSY
    } drain_state_e;

    drain_state_e state;
    drain_state_e state_nxt;
    mem_wbeat_t   beat_q;
    logic         take;

    // Free now or emptied on this edge
    assign pop_o = (state == IDLE) || mem_wready_i;
    assign take  = pop_o & head_valid_i;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: if (take) state_nxt = BUSY;
            BUSY: if (mem_wready_i && !take) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Only reloaded once the old beat is accepted
    always_ff @(posedge clk) begin
        if (take) begin
            beat_q <= head_beat_i;
        end
    end

    assign mem_wvalid_o = (state == BUSY);
    assign mem_wbeat_o  = beat_q;

endmodule

//--- hdl/dcache_wb_top.sv
`timescale 1ns/1ps

module dcache_wb_top (
    input  logic                   clk,
    input  logic                   rst,

    // CPU write
    input  logic                   cpu_wvalid_i,
    output logic                   cpu_wready_o,
    input  wb_bus_pkg::cpu_wreq_t  cpu_wreq_i,

    // CPU read
    input  logic                   cpu_rreq_i,
    input  wb_cfg_pkg::addr_t      cpu_raddr_i,
    output wb_bus_pkg::cpu_rresp_t cpu_rresp_o,

    // Memory write channel
    output logic                   mem_wvalid_o,
    input  logic                   mem_wready_i,
    output wb_bus_pkg::mem_wbeat_t mem_wbeat_o
);

    import wb_bus_pkg::*;

    logic       head_valid;
    logic       pop;
    mem_wbeat_t head_beat;

    dcache_fifo u_fifo (
        .clk          (clk),
        .rst          (rst),
        .cpu_wvalid_i (cpu_wvalid_i),
        .cpu_wready_o (cpu_wready_o),
        .cpu_wreq_i   (cpu_wreq_i),
        .cpu_rreq_i   (cpu_rreq_i),
        .cpu_raddr_i  (cpu_raddr_i),
        .cpu_rresp_o  (cpu_rresp_o),
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_beat_o  (head_beat)
    );

    wb_drain u_drain (
        .clk          (clk),
        .rst          (rst),
        .head_valid_i (head_valid),
        .head_beat_i  (head_beat),
        .pop_o        (pop),
        .mem_wvalid_o (mem_wvalid_o),
        .mem_wready_i (mem_wready_i),
        .mem_wbeat_o  (mem_wbeat_o)
    );

endmodule

//--- verif/tb_dcache_wb.sv
`timescale 1ns/1ps

module tb_dcache_wb;

    import wb_cfg_pkg::*;
    import wb_bus_pkg::*;

    localparam int MAX_WAIT = 64;

    typedef logic [191:0] chk_t;

    logic       clk;
    logic       rst;
    logic       cpu_wvalid;
    logic       cpu_wready;
    cpu_wreq_t  cpu_wreq;
    logic       cpu_rreq;
    addr_t      cpu_raddr;
    cpu_rresp_t cpu_rresp;
    logic       mem_wvalid;
    logic       mem_wready;
    mem_wbeat_t mem_wbeat;

    // Operations from the data file
    byte        op_q[$];
    addr_t      addr_q[$];
    line_t      data_q[$];
    logic       stall_q[$];
    logic       exp_q[$];

    // Model of the queued lines and the beat held for memory
    mem_wbeat_t model_q[$];
    mem_wbeat_t drain_q[$];
    cpu_rresp_t file_resp;
    cpu_rresp_t exp_file;
    cpu_rresp_t exp_model;
    logic       rd_pending = 1'b0;
    logic       held = 1'b0;
    mem_wbeat_t held_beat;
    logic       checking;
    int         mon_errors = 0;
    int         seq_errors = 0;
    int         fails = 0;

    dcache_wb_top dut (
        .clk          (clk),
        .rst          (rst),
        .cpu_wvalid_i (cpu_wvalid),
        .cpu_wready_o (cpu_wready),
        .cpu_wreq_i   (cpu_wreq),
        .cpu_rreq_i   (cpu_rreq),
        .cpu_raddr_i  (cpu_raddr),
        .cpu_rresp_o  (cpu_rresp),
        .mem_wvalid_o (mem_wvalid),
        .mem_wready_i (mem_wready),
        .mem_wbeat_o  (mem_wbeat)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic addr_t line_addr(input addr_t addr);
        return addr & ~addr_t'((1 << OFFS_W) - 1);
    endfunction

    task automatic check_value(input string name, input chk_t got, input chk_t exp,
                               inout int count);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            count++;
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d monitor, %0d sequence, %0d other", mon_errors, seq_errors, fails);
        if (mon_errors + seq_errors + fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    task automatic fail_timeout(input string what);
        $display("Timeout: %s did not arrive within %0d cycles", what, MAX_WAIT);
        fails++;
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic load_cases();
        int    fd;
        int    n;
        string text;
        byte   op;
        addr_t addr;
        line_t data;
        int    stall;
        int    exp;
        fd = $fopen("verif/wb_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open verif/wb_cases.txt");
            fails++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(text, fd);
                if (n > 1 && text.getc(0) != "#") begin
                    n = $sscanf(text, "%c %h %h %d %d", op, addr, data, stall, exp);
                    if (n == 5) begin
                        op_q.push_back(op);
                        addr_q.push_back(addr);
                        data_q.push_back(data);
                        stall_q.push_back(stall != 0);
                        exp_q.push_back(exp != 0);
                    end else begin
                        $display("Malformed line in the cases file: %s", text);
                        fails++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic do_write(input addr_t addr, input line_t data, input logic first_ready);
        int waited;
        waited        = 0;
        cpu_wvalid    = 1'b1;
        cpu_wreq.addr = addr;
        cpu_wreq.data = data;
        @(negedge clk);
        check_value("cpu_wready_o on offer", chk_t'(cpu_wready), chk_t'(first_ready), seq_errors);
        // Blocked offer is withdrawn after one cycle
        while (first_ready && !cpu_wready && waited < MAX_WAIT) begin
            waited++;
            @(negedge clk);
        end
        if (first_ready && !cpu_wready) begin
            fail_timeout("cpu_wready_o");
        end
        step_cycle();
        cpu_wvalid = 1'b0;
    endtask

    task automatic do_read(input addr_t addr, input line_t data, input logic hit);
        cpu_rreq       = 1'b1;
        cpu_raddr      = addr;
        file_resp.hit  = hit;
        file_resp.data = data;
        step_cycle();
        cpu_rreq = 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while ((model_q.size() != 0 || drain_q.size() != 0) && waited < MAX_WAIT) begin
            waited++;
            step_cycle();
        end
        if (model_q.size() != 0 || drain_q.size() != 0) begin
            fail_timeout("drain of all queued lines");
        end
    endtask

    // Checks current outputs, then predicts the coming edge
    always @(negedge clk) begin
        logic       pop_fire;
        logic       exp_ready;
        int         hit_idx;
        int         rd_idx;
        addr_t      waddr;
        mem_wbeat_t entry;
        if (checking) begin
            if (rd_pending) begin
                check_value("cpu_rresp_o", chk_t'(cpu_rresp), chk_t'(exp_file), mon_errors);
                check_value("model read result", chk_t'(exp_model), chk_t'(exp_file),
                            mon_errors);
            end else begin
                check_value("cpu_rresp_o", chk_t'(cpu_rresp), '0, mon_errors);
            end
            check_value("mem_wvalid_o", chk_t'(mem_wvalid), chk_t'(drain_q.size() != 0),
                        mon_errors);
            if (held) begin
                check_value("mem_wbeat_o held", chk_t'(mem_wbeat), chk_t'(held_beat), mon_errors);
            end
            held      = mem_wvalid && !mem_wready;
            held_beat = mem_wbeat;

            // Head leaving on this edge takes no merge
            pop_fire = (drain_q.size() == 0 || mem_wready) && model_q.size() != 0;
            waddr    = line_addr(cpu_wreq.addr);
            hit_idx  = -1;
            rd_idx   = -1;
            foreach (model_q[i]) begin
                if (model_q[i].addr == waddr && !(pop_fire && i == 0)) hit_idx = i;
                if (model_q[i].addr == line_addr(cpu_raddr)) rd_idx = i;
            end
            exp_ready = model_q.size() < WB_DEPTH || hit_idx >= 0;
            check_value("cpu_wready_o", chk_t'(cpu_wready), chk_t'(exp_ready), mon_errors);

            rd_pending = cpu_rreq;
            exp_file   = file_resp;
            exp_model  = '0;
            if (cpu_rreq && rd_idx >= 0) begin
                exp_model.hit  = 1'b1;
                exp_model.data = model_q[rd_idx].data;
            end

            if (mem_wvalid && mem_wready && drain_q.size() != 0) begin
                check_value("mem_wbeat_o", chk_t'(mem_wbeat), chk_t'(drain_q[0]), mon_errors);
                drain_q.delete(0);
            end
            if (cpu_wvalid && exp_ready && hit_idx >= 0) model_q[hit_idx].data = cpu_wreq.data;
            if (pop_fire) drain_q.push_back(model_q.pop_front());
            if (cpu_wvalid && exp_ready && hit_idx < 0) begin
                entry.addr = waddr;
                entry.data = cpu_wreq.data;
                model_q.push_back(entry);
            end
        end
    end

    initial begin
        rst        = 1'b1;
        cpu_wvalid = 1'b0;
        cpu_wreq   = '0;
        cpu_rreq   = 1'b0;
        cpu_raddr  = '0;
        mem_wready = 1'b1;
        file_resp  = '0;
        checking   = 1'b0;
        void'($urandom(32'h61bb0ab9));
        load_cases();
        repeat (8) @(posedge clk);
        #2;
        check_value("mem_wvalid_o after reset", chk_t'(mem_wvalid), '0, seq_errors);
        check_value("cpu_rresp_o.hit after reset", chk_t'(cpu_rresp.hit), '0, seq_errors);
        check_value("cpu_wready_o after reset", chk_t'(cpu_wready), chk_t'(1'b1), seq_errors);
        rst      = 1'b0;
        checking = 1'b1;
        foreach (op_q[i]) begin
            repeat ($urandom % 3) step_cycle();
            mem_wready = !stall_q[i];
            case (op_q[i])
                "w": do_write(addr_q[i], data_q[i], exp_q[i]);
                "r": do_read(addr_q[i], data_q[i], exp_q[i]);
                default: repeat (addr_q[i]) step_cycle();
            endcase
        end
        mem_wready = 1'b1;
        wait_drained();
        repeat (2) step_cycle();
        finish_run();
    end

endmodule

//--- verif/wb_cases.txt
# op addr data stall exp   (op w = write, r = read, i = idle; stall 1 holds mem_wready_i low)
# w: exp is cpu_wready_o on offer   r: data, exp are expected line and hit   i: addr is cycles
w 00001000 11111111000000000000000000001000 0 1
w 00001008 11111111000000000000000000001008 0 1
w 00001010 11111111000000000000000000001010 0 1
w 00002004 22222222000000000000000000002004 0 1
i 0000000c 0 0 0
r 00001000 00000000000000000000000000000000 0 0
r 00002000 00000000000000000000000000000000 0 0
w 00003000 33333333aaaaaaaa0000000000003000 1 1
w 00004000 44444444000000000000000000000001 1 1
w 00004008 44444444000000000000000000000002 1 1
r 00004000 44444444000000000000000000000002 1 1
w 0000400c 44444444000000000000000000000003 1 1
r 00004004 44444444000000000000000000000003 1 1
r 00003000 00000000000000000000000000000000 1 0
r 00005000 00000000000000000000000000000000 1 0
w 00005000 55555555000000000000000000005000 1 1
w 00006000 66666666000000000000000000000001 1 1
w 00007000 77777777000000000000000000007000 1 1
w 00008000 88888888000000000000000000008000 1 0
w 00006008 66666666000000000000000000000002 1 1
r 00006000 66666666000000000000000000000002 1 1
r 00007004 77777777000000000000000000007000 1 1
w 00009000 99999999000000000000000000000bad 1 0
i 00000010 0 0 0
r 00006000 00000000000000000000000000000000 0 0
w 00009000 99999999000000000000000000000001 0 1
w 0000a000 aaaaaaaa00000000000000000000a000 0 1
w 00009004 99999999000000000000000000000002 0 1
w 0000b000 bbbbbbbb00000000000000000000b000 0 1
r 0000c000 00000000000000000000000000000000 0 0
i 00000010 0 0 0

//--- list.f
hdl/wb_cfg_pkg.sv
hdl/wb_bus_pkg.sv
hdl/lutram_1w_mr.sv
hdl/dcache_fifo.sv
hdl/wb_drain.sv
hdl/dcache_wb_top.sv
verif/tb_dcache_wb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache_wb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= All tests passed!

SOURCES := $(wildcard hdl/*.sv verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
